// ==== common/regmap_pkg.sv ====
// Register map of the bitplane video block
// Word addresses on the register bus and the BPLCON0 field positions

package regmap_pkg;

  //////////////////////////////
  // Register bus
  //////////////////////////////

  // One word index of the chip register space
  typedef logic [7:0] rga_t;

  //////////////////////////////
  // Write register addresses
  //////////////////////////////

  // BPLCON0 at byte offset 0x100
  localparam rga_t ADDR_BPLCON0 = 8'h80;

  // BPL1DAT at byte offset 0x110
  // BPL2DAT to BPL6DAT follow on consecutive words
  localparam rga_t ADDR_BPL1DAT = 8'h88;

  // COLOR00 at byte offset 0x180
  // 32 colour registers up to 0xDF
  localparam rga_t ADDR_COLOR00 = 8'hC0;

  //////////////////////////////
  // BPLCON0 fields
  //////////////////////////////

  // Number of bitplanes in use
  localparam int BPU_MSB = 14;
  localparam int BPU_LSB = 12;

endpackage : regmap_pkg

// ==== common/video_pkg.sv ====
// Video pipeline types for the bitplane display path
// Plane words, pixel indexes and 12-bit colours

package video_pkg;

  //////////////////////////////
  // Playfield constants
  //////////////////////////////

  // Lores bitplanes BPL1 to BPL6
  localparam int NUM_PLANES = 6;

  // Pixels shifted out of one data word
  localparam int WORD_PIXELS = 16;

  //////////////////////////////
  // Playfield types
  //////////////////////////////

  // One bitplane data word with the leftmost pixel in the MSB
  typedef logic [WORD_PIXELS-1:0] plane_word_t;

  // Per-plane enable with plane 1 in bit 0
  typedef logic [NUM_PLANES-1:0] plane_mask_t;

  // Pixel index built from the planes with plane 1 in bit 0
  typedef logic [NUM_PLANES-1:0] pix_idx_t;

  //////////////////////////////
  // Colour types
  //////////////////////////////

  // Index into the 32-entry colour table
  typedef logic [4:0] clut_idx_t;

  // 4 bits per component with red on top
  typedef logic [11:0] rgb_t;

endpackage : video_pkg

// ==== verilog/control_regs.sv ====
// Register write decode for the bitplane video path
// Registers the bus one cycle, keeps BPLCON0 and steers the datapath

`timescale 1ns/1ps

module control_regs (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   reg_wr,
  input  regmap_pkg::rga_t       rga,
  input  video_pkg::plane_word_t db_in,
  input  logic                   a1k_mode,
  output logic                   col_wr,
  output video_pkg::clut_idx_t   col_idx,
  output video_pkg::rgb_t        col_rgb,
  output logic                   plane_wr,
  output logic [2:0]             plane_sel,
  output video_pkg::plane_word_t plane_data,
  output logic                   load,
  output video_pkg::plane_mask_t plane_mask,
  output logic                   ehb_mode
);

  import regmap_pkg::*;
  import video_pkg::*;

  logic        wr_q;
  rga_t        rga_q;
  plane_word_t db_q;
  rga_t        plane_off;
  logic        hit_bplcon0;
  logic        hit_bpldat;
  logic        hit_color;
  logic        bpl1_wr;
  logic [2:0]  bpu;
  plane_mask_t bpu_mask;

  //////////////////////////////
  // Bus input stage
  //////////////////////////////

  // Write strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= reg_wr;
    end
  end

  // Address and data in step with the strobe
  always_ff @(posedge clk) begin
    rga_q <= rga;
    db_q  <= db_in;
  end

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign plane_off   = rga_q - ADDR_BPL1DAT;
  assign hit_bplcon0 = (rga_q == ADDR_BPLCON0);
  // BPL1DAT to BPL6DAT
  assign hit_bpldat  = (rga_q >= ADDR_BPL1DAT) && (plane_off < rga_t'(NUM_PLANES));
  // COLOR00 to COLOR31 share the top three address bits
  assign hit_color   = (rga_q[7:5] == ADDR_COLOR00[7:5]);

  // Colour table write applied at the next edge
  assign col_wr  = wr_q & hit_color;
  assign col_idx = rga_q[4:0];
  assign col_rgb = db_q[11:0];

  // Holding register write
  assign plane_wr   = wr_q & hit_bpldat;
  assign plane_sel  = plane_off[2:0];
  assign plane_data = db_q;

  // BPL1DAT write kicks off a new word
  assign bpl1_wr = plane_wr & (plane_off == '0);

  //////////////////////////////
  // BPLCON0 and plane enables
  //////////////////////////////

  // Contiguous low-plane mask with 7 clamped to 6
  always_comb begin
    case (bpu)
      3'd0:    bpu_mask = 6'b000000;
      3'd1:    bpu_mask = 6'b000001;
      3'd2:    bpu_mask = 6'b000011;
      3'd3:    bpu_mask = 6'b000111;
      3'd4:    bpu_mask = 6'b001111;
      3'd5:    bpu_mask = 6'b011111;
      default: bpu_mask = 6'b111111;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bpu        <= 3'd0;
      load       <= 1'b0;
      plane_mask <= '0;
    end else begin
      if (wr_q && hit_bplcon0) begin
        bpu <= db_q[BPU_MSB:BPU_LSB];
      end
      // Mask follows the BPU value current at the BPL1DAT write
      if (bpl1_wr) begin
        plane_mask <= bpu_mask;
      end
      load <= bpl1_wr;
    end
  end

  // Six planes give EHB except on the A1000
  assign ehb_mode = (bpu >= 3'd6) & ~a1k_mode;

endmodule : control_regs

// ==== playfield/bitplane_shifter.sv ====
// Bitplane shifter
// Six holding registers loaded by the CPU, copied in parallel into
// six shifters that emit one lores pixel per clock, MSB first

`timescale 1ns/1ps

module bitplane_shifter (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   plane_wr,
  input  logic [2:0]             plane_sel,
  input  video_pkg::plane_word_t plane_data,
  input  logic                   load,
  input  video_pkg::plane_mask_t plane_mask,
  output video_pkg::pix_idx_t    pix_idx,
  output logic                   pix_valid
);

  import video_pkg::*;

  localparam int CNT_W = $clog2(WORD_PIXELS);

  plane_word_t        hold_q  [NUM_PLANES];
  plane_word_t        shift_q [NUM_PLANES];
  logic [CNT_W-1:0]   pix_cnt;

  //////////////////////////////
  // Holding registers
  //////////////////////////////

  // BPLxDAT writes land here
  always_ff @(posedge clk) begin
    if (plane_wr) begin
      hold_q[plane_sel] <= plane_data;
    end
  end

  //////////////////////////////
  // Shift registers
  //////////////////////////////

  // Parallel load on BPL1DAT or shift left while a word runs
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PLANES; p++) begin
      if (load) begin
        shift_q[p] <= hold_q[p];
      end else if (pix_valid) begin
        shift_q[p] <= {shift_q[p][WORD_PIXELS-2:0], 1'b0};
      end
    end
  end

  //////////////////////////////
  // Pixel counter
  //////////////////////////////

  // A new load restarts the word from pixel 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt   <= '0;
      pix_valid <= 1'b0;
    end else if (load) begin
      pix_cnt   <= '0;
      pix_valid <= 1'b1;
    end else if (pix_valid) begin
      pix_cnt <= pix_cnt + 1'b1;
      // Last pixel of the word
      if (pix_cnt == CNT_W'(WORD_PIXELS - 1)) begin
        pix_valid <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Pixel index
  //////////////////////////////

  // Leftmost bit of each plane with disabled planes read as 0
  always_comb begin
    for (int p = 0; p < NUM_PLANES; p++) begin
      pix_idx[p] = shift_q[p][WORD_PIXELS-1] & plane_mask[p];
    end
  end

endmodule : bitplane_shifter

// ==== color/color_table.sv ====
// Colour look-up table
// 32 entries of 12-bit RGB, CPU write port and one registered read

`timescale 1ns/1ps

module color_table (
  input  logic                 clk,
  input  logic                 col_wr,
  input  video_pkg::clut_idx_t col_idx,
  input  video_pkg::rgb_t      col_rgb,
  input  video_pkg::clut_idx_t rd_idx,
  output video_pkg::rgb_t      clut_rgb
);

  import video_pkg::*;

  // Inferred 32 x 12 RAM written by the CPU
  rgb_t clut_mem [32];

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (col_wr) begin
      clut_mem[col_idx] <= col_rgb;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Read every cycle with one clock of latency
  always_ff @(posedge clk) begin
    clut_rgb <= clut_mem[rd_idx];
  end

endmodule : color_table

// ==== color/color_mixer.sv ====
// Final colour stage
// Extra-half-brite halving, blanking and the RGB output register

`timescale 1ns/1ps

module color_mixer (
  input  logic                clk,
  input  logic                arst_n,
  input  video_pkg::pix_idx_t pix_idx,
  input  logic                pix_valid,
  input  logic                ehb_mode,
  input  video_pkg::rgb_t     clut_rgb,
  output logic [3:0]          red,
  output logic [3:0]          green,
  output logic [3:0]          blue,
  output logic                blank_n
);

  import video_pkg::*;

  logic valid_d;
  logic half_d;
  rgb_t half_rgb;
  rgb_t rgb_q;

  //////////////////////////////
  // Align with table output
  //////////////////////////////

  // Plane 6 bit and valid lag the table read by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_d <= 1'b0;
      half_d  <= 1'b0;
    end else begin
      valid_d <= pix_valid;
      half_d  <= pix_idx[NUM_PLANES-1];
    end
  end

  // Each component shifted right one bit
  assign half_rgb = {1'b0, clut_rgb[11:9], 1'b0, clut_rgb[7:5], 1'b0, clut_rgb[3:1]};

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rgb_q   <= '0;
      blank_n <= 1'b0;
    end else begin
      blank_n <= valid_d;
      if (!valid_d) begin
        // Outside a word the output is black
        rgb_q <= '0;
      end else if (ehb_mode && half_d) begin
        rgb_q <= half_rgb;
      end else begin
        rgb_q <= clut_rgb;
      end
    end
  end

  assign red   = rgb_q[11:8];
  assign green = rgb_q[7:4];
  assign blue  = rgb_q[3:0];

endmodule : color_mixer

// ==== verilog/bitplane_video_top.sv ====
// Bitplane video path top level
// Register decode, bitplane shifter, colour table and output mixer

`timescale 1ns/1ps

module bitplane_video_top (
  input  logic                  clk,
  input  logic                  arst_n,
  // Register bus
  input  logic                  reg_wr,
  input  regmap_pkg::rga_t      rga,
  input  video_pkg::plane_word_t db_in,
  // Configuration
  input  logic                  a1k_mode,
  // Video output
  output logic [3:0]            red,
  output logic [3:0]            green,
  output logic [3:0]            blue,
  output logic                  blank_n
);

  //////////////////////////////
  // Internal wiring
  //////////////////////////////

  // Colour table write port
  logic                   col_wr;
  video_pkg::clut_idx_t   col_idx;
  video_pkg::rgb_t        col_rgb;

  // Bitplane holding register writes
  logic                   plane_wr;
  logic [2:0]             plane_sel;
  video_pkg::plane_word_t plane_data;

  // Shifter load and active planes
  logic                   load;
  video_pkg::plane_mask_t plane_mask;

  // Extra-half-brite enable
  logic                   ehb_mode;

  // Pixel stream out of the shifter
  video_pkg::pix_idx_t    pix_idx;
  logic                   pix_valid;

  // Colour table output one cycle behind pix_idx
  video_pkg::rgb_t        clut_rgb;

  //////////////////////////////
  // Register decode
  //////////////////////////////

  control_regs u_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_wr     (reg_wr),
    .rga        (rga),
    .db_in      (db_in),
    .a1k_mode   (a1k_mode),
    .col_wr     (col_wr),
    .col_idx    (col_idx),
    .col_rgb    (col_rgb),
    .plane_wr   (plane_wr),
    .plane_sel  (plane_sel),
    .plane_data (plane_data),
    .load       (load),
    .plane_mask (plane_mask),
    .ehb_mode   (ehb_mode)
  );

  //////////////////////////////
  // Pixel generation
  //////////////////////////////

  bitplane_shifter u_shifter (
    .clk        (clk),
    .arst_n     (arst_n),
    .plane_wr   (plane_wr),
    .plane_sel  (plane_sel),
    .plane_data (plane_data),
    .load       (load),
    .plane_mask (plane_mask),
    .pix_idx    (pix_idx),
    .pix_valid  (pix_valid)
  );

  // Low five index bits address the table
  color_table u_clut (
    .clk      (clk),
    .col_wr   (col_wr),
    .col_idx  (col_idx),
    .col_rgb  (col_rgb),
    .rd_idx   (pix_idx[4:0]),
    .clut_rgb (clut_rgb)
  );

  color_mixer u_mixer (
    .clk       (clk),
    .arst_n    (arst_n),
    .pix_idx   (pix_idx),
    .pix_valid (pix_valid),
    .ehb_mode  (ehb_mode),
    .clut_rgb  (clut_rgb),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .blank_n   (blank_n)
  );

endmodule : bitplane_video_top

// ==== testbench/video_checker.sv ====
// Scoreboard for the bitplane video path
// Models register writes, predicts each output pixel and compares

`timescale 1ns/1ps

module video_checker (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   reg_wr,
  input regmap_pkg::rga_t       rga,
  input video_pkg::plane_word_t db_in,
  input logic                   a1k_mode,
  input logic [3:0]             red,
  input logic [3:0]             green,
  input logic [3:0]             blue,
  input logic                   blank_n
);

  import regmap_pkg::*;
  import video_pkg::*;

  // Set by the testbench before each test
  string       test_name = "reset_state";
  int          err_cnt   = 0;
  int          pix_cnt   = 0;

  int          cyc       = 0;
  int          start_cyc = -100;
  int          bpu_m     = 0;
  int          plane_off;
  int          pix_k;
  rgb_t        clut_m  [32];
  plane_word_t plane_m [NUM_PLANES];
  rgb_t        exp_q   [WORD_PIXELS];

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Colour of pixel k taken MSB first from the model planes and table
  function automatic rgb_t ref_pixel(input int k, input int bpu, input logic a1k);
    int         n;
    logic [5:0] idx;
    rgb_t       c;
    // BPU above 6 behaves as 6
    n   = (bpu > NUM_PLANES) ? NUM_PLANES : bpu;
    idx = '0;
    for (int p = 0; p < n; p++) begin
      idx[p] = plane_m[p][WORD_PIXELS-1-k];
    end
    c = clut_m[idx[4:0]];
    // Plane 6 halves every component in EHB
    if (n == NUM_PLANES && !a1k && idx[5]) begin
      c = {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};
    end
    return c;
  endfunction

  //////////////////////////////
  // Register write monitor
  //////////////////////////////

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bpu_m = 0;
    end else begin
      cyc = cyc + 1;
      if (reg_wr) begin
        plane_off = rga - ADDR_BPL1DAT;
        if (rga == ADDR_BPLCON0) begin
          bpu_m = db_in[BPU_MSB:BPU_LSB];
        end else if (rga >= ADDR_COLOR00 && rga < ADDR_COLOR00 + 32) begin
          clut_m[rga - ADDR_COLOR00] = db_in[11:0];
        end else if (rga >= ADDR_BPL1DAT && plane_off < NUM_PLANES) begin
          plane_m[plane_off] = db_in;
          // BPL1DAT starts a word so all 16 pixels are predicted here
          if (plane_off == 0) begin
            for (int k = 0; k < WORD_PIXELS; k++) begin
              exp_q[k] = ref_pixel(k, bpu_m, a1k_mode);
            end
            start_cyc = cyc;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Output compare
  //////////////////////////////

  // Pixel k is on the outputs after edge E0+4+k and is checked mid-cycle
  always @(negedge clk) begin
    if (arst_n) begin
      pix_k = cyc - start_cyc - 4;
      if (pix_k >= 0 && pix_k < WORD_PIXELS) begin
        pix_cnt = pix_cnt + 1;
        if (blank_n !== 1'b1 || {red, green, blue} !== exp_q[pix_k]) begin
          err_cnt = err_cnt + 1;
          $display("FAIL %s pixel %0d expected rgb %h blank_n 1 actual rgb %h blank_n %b",
                   test_name, pix_k, exp_q[pix_k], {red, green, blue}, blank_n);
        end
      end else if (blank_n !== 1'b0 || {red, green, blue} !== 12'h000) begin
        // Between words the output is blanked and black
        err_cnt = err_cnt + 1;
        $display("FAIL %s idle cycle expected rgb 000 blank_n 0 actual rgb %h blank_n %b",
                 test_name, {red, green, blue}, blank_n);
      end
    end
  end

endmodule : video_checker

// ==== testbench/tb_bitplane_video.sv ====
// Testbench for the bitplane video path
// Drives register writes per test and reports a summary

`timescale 1ns/1ps

module tb_bitplane_video;

  import regmap_pkg::*;
  import video_pkg::*;

  logic        clk;
  logic        arst_n;
  logic        reg_wr;
  rga_t        rga;
  plane_word_t db_in;
  logic        a1k_mode;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;
  logic        blank_n;

  integer      seed = 2;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          err_base;
  int          pix_base;
  bit          test_bad;
  plane_word_t words [NUM_PLANES];

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  bitplane_video_top u_dut (
    .clk(clk), .arst_n(arst_n), .reg_wr(reg_wr), .rga(rga), .db_in(db_in),
    .a1k_mode(a1k_mode), .red(red), .green(green), .blue(blue), .blank_n(blank_n)
  );

  video_checker u_chk (
    .clk(clk), .arst_n(arst_n), .reg_wr(reg_wr), .rga(rga), .db_in(db_in),
    .a1k_mode(a1k_mode), .red(red), .green(green), .blue(blue), .blank_n(blank_n)
  );

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  // One-cycle write strobe driven on the falling edge
  task automatic write_reg(input rga_t addr, input plane_word_t data);
    @(negedge clk);
    reg_wr = 1'b1;
    rga    = addr;
    db_in  = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic write_colors();
    for (int i = 0; i < 32; i++) begin
      write_reg(rga_t'(ADDR_COLOR00 + i), plane_word_t'($random(seed) & 16'h0fff));
    end
  endtask

  task automatic set_bpu(input int n);
    write_reg(ADDR_BPLCON0, plane_word_t'(n << BPU_LSB));
  endtask

  // Random data in the lowest n planes and zero above
  task automatic random_words(input int n);
    for (int p = 0; p < NUM_PLANES; p++) begin
      words[p] = (p < n) ? plane_word_t'($random(seed)) : '0;
    end
  endtask

  // Upper planes first so the final BPL1DAT write triggers the load
  task automatic load_word();
    for (int p = NUM_PLANES - 1; p >= 0; p--) begin
      write_reg(rga_t'(ADDR_BPL1DAT + p), words[p]);
    end
  endtask

  // Word start then word end with a timeout on each
  task automatic wait_word();
    int t;
    t = 0;
    while (blank_n !== 1'b1 && t < 20) begin
      @(negedge clk);
      t++;
    end
    if (blank_n !== 1'b1) begin
      $display("Timeout: blank_n never went high in test %s", u_chk.test_name);
      test_bad = 1'b1;
    end else begin
      t = 0;
      while (blank_n !== 1'b0 && t < 40) begin
        @(negedge clk);
        t++;
      end
      if (blank_n !== 1'b0) begin
        $display("Timeout: blank_n stayed high after the word in test %s", u_chk.test_name);
        test_bad = 1'b1;
      end
    end
    // Some idle cycles for the blank check
    repeat (3) @(negedge clk);
  endtask

  //////////////////////////////
  // Test bookkeeping
  //////////////////////////////

  task automatic begin_test(input string name);
    u_chk.test_name = name;
    err_base = u_chk.err_cnt;
    pix_base = u_chk.pix_cnt;
    test_bad = 1'b0;
  endtask

  task automatic end_test(input int exp_pix);
    if (u_chk.pix_cnt - pix_base != exp_pix) begin
      $display("Test %s compared %0d pixels instead of %0d", u_chk.test_name,
               u_chk.pix_cnt - pix_base, exp_pix);
      test_bad = 1'b1;
    end
    if (u_chk.err_cnt != err_base) begin
      test_bad = 1'b1;
    end
    if (test_bad) begin
      fail_cnt++;
      $display("Test %s failed", u_chk.test_name);
    end else begin
      pass_cnt++;
      $display("Test %s passed", u_chk.test_name);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    arst_n   = 1'b0;
    reg_wr   = 1'b0;
    rga      = '0;
    db_in    = '0;
    a1k_mode = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Outputs stay blank with no load
    begin_test("reset_state");
    repeat (8) @(negedge clk);
    end_test(0);

    begin_test("one_plane");
    write_colors();
    set_bpu(1);
    random_words(1);
    load_word();
    wait_word();
    end_test(16);

    begin_test("five_planes");
    set_bpu(5);
    random_words(5);
    load_word();
    wait_word();
    end_test(16);

    // Plane 6 forced to a mix of set and clear pixels
    begin_test("extra_half_brite");
    set_bpu(6);
    random_words(6);
    words[5][3:0] = 4'b1010;
    load_word();
    wait_word();
    end_test(16);

    // Same words without halving
    begin_test("a1000_mode");
    a1k_mode = 1'b1;
    load_word();
    wait_word();
    end_test(16);
    a1k_mode = 1'b0;

    // Planes 4 to 6 carry data but are masked
    begin_test("masked_planes");
    set_bpu(3);
    random_words(6);
    words[3][0] = 1'b1;
    words[4][0] = 1'b1;
    words[5][0] = 1'b1;
    load_word();
    wait_word();
    end_test(16);

    $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && u_chk.err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_bitplane_video

// ==== bitplane_video.f ====
common/regmap_pkg.sv
common/video_pkg.sv
verilog/control_regs.sv
playfield/bitplane_shifter.sv
color/color_table.sv
color/color_mixer.sv
verilog/bitplane_video_top.sv
testbench/video_checker.sv
testbench/tb_bitplane_video.sv
